//--- common/fractal_params.svh
// fractal pixel source parameters
// fixed-point format, core count, register map and default frame
`ifndef FRACTAL_PARAMS_SVH
`define FRACTAL_PARAMS_SVH

`define FRAC_BITS      24               // signed 8.24
`define DATA_W         32
`define ITER_W         16
`define CORE_COUNT     4
`define REG_COUNT      8
`define AXIL_ADDR_W    8

`define DEF_X_SIZE     640
`define DEF_Y_SIZE     480
`define DEF_X_START    32'shFE000000    // -2.0
`define DEF_Y_START    32'shFE800000    // -1.5
`define DEF_STEP       32'sh0001999A
`define ESCAPE_LIMIT   32'sh04000000    // 4.0

`define REG_MAX_ITER   0
`define REG_CTRL       1
`define RESET_MAX_ITER 100

`endif

//--- common/fractal_pkg.sv
// fractal pixel source types
// coordinates, pixels, configuration and FSM encodings
`include "fractal_params.svh"

package fractal_pkg;

    typedef logic signed [`DATA_W-1:0] fixed_t;

    typedef struct packed {
        fixed_t cx;
        fixed_t cy;
        logic   sof;    // raster 0,0
        logic   eol;    // last column
    } coord_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic [`ITER_W-1:0] max_iter;
        logic               run;
    } cfg_t;

    typedef enum logic [1:0] {AWAIT_RADD, AWAIT_FETCH, AWAIT_READ} rd_state_e;

    typedef enum logic [2:0] {
        AWAIT_WADD_AND_DATA,
        AWAIT_WDATA,
        AWAIT_WADD,
        AWAIT_WRITE,
        AWAIT_RESP
    } wr_state_e;

    typedef enum logic [1:0] {IDLE, FILL, WAIT_CORE, SEND} sched_state_e;

    typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axi_resp_e;

endpackage

//--- design/axi_lite_regs.sv
// AXI-Lite register file
// eight words, word 0 max iterations, word 1 bit 0 run
`timescale 1ns/10ps
`include "fractal_params.svh"

module axi_lite_regs (
    input  logic                    out_stream_aclk,
    input  logic                    axi_resetn,
    input  logic [`AXIL_ADDR_W-1:0] s_axi_lite_araddr_i,
    input  logic                    s_axi_lite_arvalid_i,
    output logic                    s_axi_lite_arready_o,
    input  logic [`AXIL_ADDR_W-1:0] s_axi_lite_awaddr_i,
    input  logic                    s_axi_lite_awvalid_i,
    output logic                    s_axi_lite_awready_o,
    input  logic [31:0]             s_axi_lite_wdata_i,
    input  logic                    s_axi_lite_wvalid_i,
    output logic                    s_axi_lite_wready_o,
    input  logic                    s_axi_lite_bready_i,
    output logic [1:0]              s_axi_lite_bresp_o,
    output logic                    s_axi_lite_bvalid_o,
    output logic [31:0]             s_axi_lite_rdata_o,
    input  logic                    s_axi_lite_rready_i,
    output logic [1:0]              s_axi_lite_rresp_o,
    output logic                    s_axi_lite_rvalid_o,
    output fractal_pkg::cfg_t       cfg_o
);

    localparam int IDX_W = $clog2(`REG_COUNT);

    logic [31:0]           regs [`REG_COUNT];
    logic [IDX_W-1:0]      rd_idx, wr_idx;
    logic                  rd_err, wr_err;
    logic [31:0]           rdata, wdata;
    fractal_pkg::rd_state_e rd_state;
    fractal_pkg::wr_state_e wr_state;

    ////////////////////////////////////////
    // read channel
    ////////////////////////////////////////
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            rd_state <= fractal_pkg::AWAIT_RADD;
        end else begin
            case (rd_state)
                fractal_pkg::AWAIT_RADD: begin
                    if (s_axi_lite_arvalid_i) begin
                        rd_idx   <= s_axi_lite_araddr_i[2 +: IDX_W];
                        rd_err   <= |s_axi_lite_araddr_i[`AXIL_ADDR_W-1:2+IDX_W];
                        rd_state <= fractal_pkg::AWAIT_FETCH;
                    end
                end
                fractal_pkg::AWAIT_FETCH: begin
                    rdata    <= rd_err ? 32'd0 : regs[rd_idx];
                    rd_state <= fractal_pkg::AWAIT_READ;
                end
                fractal_pkg::AWAIT_READ: begin
                    if (s_axi_lite_rready_i) rd_state <= fractal_pkg::AWAIT_RADD;
                end
                default: rd_state <= fractal_pkg::AWAIT_RADD;
            endcase
        end
    end

    assign s_axi_lite_arready_o = (rd_state == fractal_pkg::AWAIT_RADD);
    assign s_axi_lite_rvalid_o  = (rd_state == fractal_pkg::AWAIT_READ);
    assign s_axi_lite_rdata_o   = rdata;
    assign s_axi_lite_rresp_o   = rd_err ? fractal_pkg::RESP_SLVERR : fractal_pkg::RESP_OKAY;

    ////////////////////////////////////////
    // write channel, address and data in either order
    ////////////////////////////////////////
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_state <= fractal_pkg::AWAIT_WADD_AND_DATA;
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= 32'd0;
            regs[`REG_MAX_ITER] <= `RESET_MAX_ITER;
        end else begin
            case (wr_state)
                fractal_pkg::AWAIT_WADD_AND_DATA: begin
                    if (s_axi_lite_awvalid_i) begin
                        wr_idx <= s_axi_lite_awaddr_i[2 +: IDX_W];
                        wr_err <= |s_axi_lite_awaddr_i[`AXIL_ADDR_W-1:2+IDX_W];
                    end
                    if (s_axi_lite_wvalid_i) wdata <= s_axi_lite_wdata_i;
                    case ({s_axi_lite_awvalid_i, s_axi_lite_wvalid_i})
                        2'b10:   wr_state <= fractal_pkg::AWAIT_WDATA;
                        2'b01:   wr_state <= fractal_pkg::AWAIT_WADD;
                        2'b11:   wr_state <= fractal_pkg::AWAIT_WRITE;
                        default: wr_state <= fractal_pkg::AWAIT_WADD_AND_DATA;
                    endcase
                end
                fractal_pkg::AWAIT_WDATA: begin  // have address
                    if (s_axi_lite_wvalid_i) begin
                        wdata    <= s_axi_lite_wdata_i;
                        wr_state <= fractal_pkg::AWAIT_WRITE;
                    end
                end
                fractal_pkg::AWAIT_WADD: begin   // have data
                    if (s_axi_lite_awvalid_i) begin
                        wr_idx   <= s_axi_lite_awaddr_i[2 +: IDX_W];
                        wr_err   <= |s_axi_lite_awaddr_i[`AXIL_ADDR_W-1:2+IDX_W];
                        wr_state <= fractal_pkg::AWAIT_WRITE;
                    end
                end
                fractal_pkg::AWAIT_WRITE: begin
                    if (!wr_err) regs[wr_idx] <= wdata;
                    wr_state <= fractal_pkg::AWAIT_RESP;
                end
                fractal_pkg::AWAIT_RESP: begin
                    if (s_axi_lite_bready_i) wr_state <= fractal_pkg::AWAIT_WADD_AND_DATA;
                end
                default: wr_state <= fractal_pkg::AWAIT_WADD_AND_DATA;
            endcase
        end
    end

    assign s_axi_lite_awready_o = (wr_state == fractal_pkg::AWAIT_WADD_AND_DATA) ||
                                  (wr_state == fractal_pkg::AWAIT_WADD);
    assign s_axi_lite_wready_o  = (wr_state == fractal_pkg::AWAIT_WADD_AND_DATA) ||
                                  (wr_state == fractal_pkg::AWAIT_WDATA);
    assign s_axi_lite_bvalid_o  = (wr_state == fractal_pkg::AWAIT_RESP);
    assign s_axi_lite_bresp_o   = wr_err ? fractal_pkg::RESP_SLVERR : fractal_pkg::RESP_OKAY;

    assign cfg_o.max_iter = regs[`REG_MAX_ITER][`ITER_W-1:0];
    assign cfg_o.run      = regs[`REG_CTRL][0];

    // no new write address while a response is pending
    a_no_aw_during_b: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        !(s_axi_lite_bvalid_o && s_axi_lite_awready_o));

endmodule

//--- fractal/pixel_coord_gen.sv
// raster position and complex-plane coordinate stepper
`timescale 1ns/10ps
`include "fractal_params.svh"

module pixel_coord_gen #(
    parameter int                  X_SIZE  = `DEF_X_SIZE,
    parameter int                  Y_SIZE  = `DEF_Y_SIZE,
    parameter fractal_pkg::fixed_t X_START = `DEF_X_START,
    parameter fractal_pkg::fixed_t Y_START = `DEF_Y_START,
    parameter fractal_pkg::fixed_t STEP    = `DEF_STEP
) (
    input  logic                out_stream_aclk,
    input  logic                axi_resetn,
    input  logic                advance_i,
    output fractal_pkg::coord_t coord_o
);

    localparam int XW = $clog2(X_SIZE);
    localparam int YW = $clog2(Y_SIZE);

    logic [XW-1:0]       x;
    logic [YW-1:0]       y;
    fractal_pkg::fixed_t cx, cy;
    logic                last_x, last_y;

    assign last_x = (x == XW'(X_SIZE - 1));
    assign last_y = (y == YW'(Y_SIZE - 1));

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            x  <= '0;
            y  <= '0;
            cx <= X_START;
            cy <= Y_START;
        end else if (advance_i) begin
            if (last_x) begin
                x  <= '0;
                cx <= X_START;
                if (last_y) begin   // frame wraps
                    y  <= '0;
                    cy <= Y_START;
                end else begin
                    y  <= y + 1'b1;
                    cy <= cy + STEP;
                end
            end else begin
                x  <= x + 1'b1;
                cx <= cx + STEP;
            end
        end
    end

    assign coord_o.cx  = cx;
    assign coord_o.cy  = cy;
    assign coord_o.sof = (x == '0) && (y == '0);
    assign coord_o.eol = last_x;

endmodule

//--- fractal/escape_core.sv
// Mandelbrot escape-time iterator in signed 8.24
// one pixel per start, result held while done is high
`timescale 1ns/10ps
`include "fractal_params.svh"

module escape_core (
    input  logic                out_stream_aclk,
    input  logic                axi_resetn,
    input  logic                start_i,
    input  fractal_pkg::coord_t c_i,
    input  logic [`ITER_W-1:0]  max_iter_i,
    output logic                done_o,
    output logic [`ITER_W-1:0]  iter_o,
    output logic [1:0]          flags_o     // {sof, eol}
);

    localparam int WW = 2 * `DATA_W;

    logic                     busy, done, stop;
    fractal_pkg::fixed_t      zx, zy, cx, cy;
    logic [`ITER_W-1:0]       cnt;
    logic [1:0]               flags;
    logic signed [WW-1:0]     zx2, zy2, zxy, mag;

    // full-width products back to 8.24 scale
    always_comb begin
        zx2  = (WW'(zx) * WW'(zx)) >>> `FRAC_BITS;
        zy2  = (WW'(zy) * WW'(zy)) >>> `FRAC_BITS;
        zxy  = (WW'(zx) * WW'(zy)) >>> `FRAC_BITS;
        mag  = zx2 + zy2;
        stop = (mag > `ESCAPE_LIMIT) || (cnt == max_iter_i);
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start_i) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && stop) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (start_i) begin
            zx    <= '0;
            zy    <= '0;
            cnt   <= '0;
            cx    <= c_i.cx;
            cy    <= c_i.cy;
            flags <= {c_i.sof, c_i.eol};
        end else if (busy && !stop) begin
            zx  <= fractal_pkg::fixed_t'(zx2 - zy2 + WW'(cx));
            zy  <= fractal_pkg::fixed_t'((zxy <<< 1) + WW'(cy));
            cnt <= cnt + 1'b1;
        end
    end

    assign done_o  = done;
    assign iter_o  = cnt;
    assign flags_o = flags;

    // scheduler must wait for done before restarting
    a_no_start_busy: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        busy |-> !start_i);

endmodule

//--- fractal/core_scheduler.sv
// in-order core scheduler and AXI4-Stream master
// fills the cores, then collects round robin in raster order
`timescale 1ns/10ps
`include "fractal_params.svh"

module core_scheduler (
    input  logic                   out_stream_aclk,
    input  logic                   axi_resetn,
    input  logic                   run_i,
    input  fractal_pkg::coord_t    coord_i,
    input  logic [`CORE_COUNT-1:0] done_i,
    input  logic [`ITER_W-1:0]     iter_i [`CORE_COUNT],
    input  logic [1:0]             flags_i [`CORE_COUNT],  // {sof, eol}
    input  logic                   out_stream_tready_i,
    output logic                   advance_o,
    output logic [`CORE_COUNT-1:0] start_o,
    output logic [31:0]            out_stream_tdata_o,
    output logic [3:0]             out_stream_tkeep_o,
    output logic                   out_stream_tlast_o,
    output logic                   out_stream_tuser_o,
    output logic                   out_stream_tvalid_o
);

    localparam int NC    = `CORE_COUNT;
    localparam int IDX_W = $clog2(NC);

    fractal_pkg::sched_state_e state;
    logic [IDX_W-1:0]          idx;
    logic                      last_core, fire, sof_q, eol_q;
    fractal_pkg::pixel_t       pix;

    assign last_core = (idx == IDX_W'(NC - 1));
    assign fire = (state == fractal_pkg::FILL) ||
                  (state == fractal_pkg::SEND && out_stream_tready_i);

    // each start takes the current coordinate, then the stepper moves on
    assign start_o   = fire ? (NC'(1) << idx) : '0;
    assign advance_o = fire;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            state <= fractal_pkg::IDLE;
            idx   <= '0;
        end else begin
            case (state)
                fractal_pkg::IDLE: begin
                    if (run_i) state <= fractal_pkg::FILL;
                end
                fractal_pkg::FILL: begin
                    idx <= last_core ? '0 : idx + 1'b1;
                    if (last_core) state <= fractal_pkg::WAIT_CORE;
                end
                fractal_pkg::WAIT_CORE: begin
                    if (done_i[idx]) state <= fractal_pkg::SEND;
                end
                fractal_pkg::SEND: begin
                    if (out_stream_tready_i) begin
                        idx   <= last_core ? '0 : idx + 1'b1;
                        state <= fractal_pkg::WAIT_CORE;
                    end
                end
                default: state <= fractal_pkg::IDLE;
            endcase
        end
    end

    // beat payload, red and green low byte, blue high byte
    always_ff @(posedge out_stream_aclk) begin
        if (state == fractal_pkg::WAIT_CORE && done_i[idx]) begin
            pix.r <= iter_i[idx][7:0];
            pix.g <= iter_i[idx][7:0];
            pix.b <= iter_i[idx][15:8];
            sof_q <= flags_i[idx][1];
            eol_q <= flags_i[idx][0];
        end
    end

    // stream beat, tuser from the sof of the core's start point
    assign out_stream_tvalid_o = (state == fractal_pkg::SEND);
    assign out_stream_tdata_o  = {8'h00, pix};
    assign out_stream_tkeep_o  = 4'hF;
    assign out_stream_tuser_o  = sof_q;
    assign out_stream_tlast_o  = eol_q;

    a_beat_stable: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        out_stream_tvalid_o && !out_stream_tready_i
        |=> $stable({out_stream_tdata_o, out_stream_tuser_o, out_stream_tlast_o}));

endmodule

//--- design/pixel_generator.sv
// Mandelbrot pixel source top level
// register file, coordinate stepper, escape cores and stream scheduler
`timescale 1ns/10ps
`include "fractal_params.svh"

module pixel_generator #(
    parameter int                  X_SIZE  = `DEF_X_SIZE,
    parameter int                  Y_SIZE  = `DEF_Y_SIZE,
    parameter fractal_pkg::fixed_t X_START = `DEF_X_START,
    parameter fractal_pkg::fixed_t Y_START = `DEF_Y_START,
    parameter fractal_pkg::fixed_t STEP    = `DEF_STEP
) (
    input  logic                    out_stream_aclk,
    input  logic                    axi_resetn,
    // stream out
    output logic [31:0]             out_stream_tdata_o,
    output logic [3:0]              out_stream_tkeep_o,
    output logic                    out_stream_tlast_o,
    input  logic                    out_stream_tready_i,
    output logic                    out_stream_tvalid_o,
    output logic                    out_stream_tuser_o,
    // AXI-Lite slave
    input  logic [`AXIL_ADDR_W-1:0] s_axi_lite_araddr_i,
    input  logic                    s_axi_lite_arvalid_i,
    output logic                    s_axi_lite_arready_o,
    input  logic [`AXIL_ADDR_W-1:0] s_axi_lite_awaddr_i,
    input  logic                    s_axi_lite_awvalid_i,
    output logic                    s_axi_lite_awready_o,
    input  logic [31:0]             s_axi_lite_wdata_i,
    input  logic                    s_axi_lite_wvalid_i,
    output logic                    s_axi_lite_wready_o,
    input  logic                    s_axi_lite_bready_i,
    output logic [1:0]              s_axi_lite_bresp_o,
    output logic                    s_axi_lite_bvalid_o,
    output logic [31:0]             s_axi_lite_rdata_o,
    input  logic                    s_axi_lite_rready_i,
    output logic [1:0]              s_axi_lite_rresp_o,
    output logic                    s_axi_lite_rvalid_o
);

    fractal_pkg::cfg_t      cfg;
    fractal_pkg::coord_t    coord;
    logic                   advance;
    logic [`CORE_COUNT-1:0] start, done;
    logic [`ITER_W-1:0]     iter [`CORE_COUNT];
    logic [1:0]             flags [`CORE_COUNT];

    axi_lite_regs regs_inst (
        .out_stream_aclk, .axi_resetn,
        .s_axi_lite_araddr_i, .s_axi_lite_arvalid_i, .s_axi_lite_arready_o,
        .s_axi_lite_awaddr_i, .s_axi_lite_awvalid_i, .s_axi_lite_awready_o,
        .s_axi_lite_wdata_i, .s_axi_lite_wvalid_i, .s_axi_lite_wready_o,
        .s_axi_lite_bready_i, .s_axi_lite_bresp_o, .s_axi_lite_bvalid_o,
        .s_axi_lite_rdata_o, .s_axi_lite_rready_i, .s_axi_lite_rresp_o,
        .s_axi_lite_rvalid_o,
        .cfg_o (cfg)
    );

    pixel_coord_gen #(
        .X_SIZE(X_SIZE), .Y_SIZE(Y_SIZE), .X_START(X_START), .Y_START(Y_START), .STEP(STEP)
    ) coord_inst (
        .out_stream_aclk, .axi_resetn,
        .advance_i (advance),
        .coord_o   (coord)
    );

    for (genvar i = 0; i < `CORE_COUNT; i++) begin : g_core
        escape_core core_inst (
            .out_stream_aclk, .axi_resetn,
            .start_i    (start[i]),
            .c_i        (coord),
            .max_iter_i (cfg.max_iter),
            .done_o     (done[i]),
            .iter_o     (iter[i]),
            .flags_o    (flags[i])
        );
    end

    core_scheduler sched_inst (
        .out_stream_aclk, .axi_resetn,
        .run_i     (cfg.run),
        .coord_i   (coord),
        .done_i    (done),
        .iter_i    (iter),
        .flags_i   (flags),
        .out_stream_tready_i,
        .advance_o (advance),
        .start_o   (start),
        .out_stream_tdata_o, .out_stream_tkeep_o, .out_stream_tlast_o,
        .out_stream_tuser_o, .out_stream_tvalid_o
    );

endmodule

//--- sim/tb_pixel_generator.sv
// testbench for the Mandelbrot pixel source
// register table over AXI-Lite, then stream frames checked against a software model
`timescale 1ns/10ps
`include "fractal_params.svh"

module tb_pixel_generator;

    localparam int                 X_SZ     = 8;
    localparam int                 Y_SZ     = 4;
    localparam logic signed [31:0] X_ORG    = 32'shFE000000;   // -2.0
    localparam logic signed [31:0] Y_ORG    = 32'shFF000000;   // -1.0
    localparam logic signed [31:0] STEP_SZ  = 32'sh00800000;   // 0.5
    localparam int                 MAX_ITER = 20;
    localparam int                 TIMEOUT  = 500;
    localparam logic [1:0]         RSP_OK   = 2'b00;
    localparam logic [1:0]         RSP_ERR  = 2'b10;

    logic        out_stream_aclk, axi_resetn;
    logic [31:0] tdata;
    logic [3:0]  tkeep;
    logic        tlast, tready, tvalid, tuser;
    logic [7:0]  araddr, awaddr;
    logic        arvalid, arready, awvalid, awready, wvalid, wready;
    logic [31:0] wdata, rdata;
    logic        bready, bvalid, rready, rvalid;
    logic [1:0]  bresp, rresp;
    int          beat_idx;

    // order: 0 address and data together, 1 address first, 2 data first
    typedef struct packed {
        logic        wr;
        logic [1:0]  order;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
    } reg_op_t;

    reg_op_t reg_ops [22] = '{
        {1'b0, 2'd0, 8'h00, 32'h0, 32'd100, RSP_OK},   // reset values
        {1'b0, 2'd0, 8'h04, 32'h0, 32'd0, RSP_OK},
        {1'b1, 2'd0, 8'h00, 32'h0000_0014, 32'h0, RSP_OK},
        {1'b1, 2'd1, 8'h04, 32'h1234_5670, 32'h0, RSP_OK},   // run bit stays 0
        {1'b1, 2'd2, 8'h08, 32'hDEAD_BEEF, 32'h0, RSP_OK},
        {1'b1, 2'd0, 8'h0C, 32'h0BAD_F00D, 32'h0, RSP_OK},
        {1'b1, 2'd1, 8'h10, 32'h5555_AAAA, 32'h0, RSP_OK},
        {1'b1, 2'd2, 8'h14, 32'hCAFE_0001, 32'h0, RSP_OK},
        {1'b1, 2'd0, 8'h18, 32'h8000_0000, 32'h0, RSP_OK},
        {1'b1, 2'd1, 8'h1C, 32'hFFFF_FFFF, 32'h0, RSP_OK},
        {1'b1, 2'd0, 8'h20, 32'h1111_1111, 32'h0, RSP_ERR},  // aliases word 0
        {1'b1, 2'd2, 8'h9C, 32'h2222_2222, 32'h0, RSP_ERR},  // aliases word 7
        {1'b0, 2'd0, 8'h00, 32'h0, 32'h0000_0014, RSP_OK},
        {1'b0, 2'd0, 8'h04, 32'h0, 32'h1234_5670, RSP_OK},
        {1'b0, 2'd0, 8'h08, 32'h0, 32'hDEAD_BEEF, RSP_OK},
        {1'b0, 2'd0, 8'h0C, 32'h0, 32'h0BAD_F00D, RSP_OK},
        {1'b0, 2'd0, 8'h10, 32'h0, 32'h5555_AAAA, RSP_OK},
        {1'b0, 2'd0, 8'h14, 32'h0, 32'hCAFE_0001, RSP_OK},
        {1'b0, 2'd0, 8'h18, 32'h0, 32'h8000_0000, RSP_OK},
        {1'b0, 2'd0, 8'h1C, 32'h0, 32'hFFFF_FFFF, RSP_OK},
        {1'b0, 2'd0, 8'h40, 32'h0, 32'h0, RSP_ERR},
        {1'b0, 2'd0, 8'hFC, 32'h0, 32'h0, RSP_ERR}
    };

    pixel_generator #(
        .X_SIZE(X_SZ), .Y_SIZE(Y_SZ), .X_START(X_ORG), .Y_START(Y_ORG), .STEP(STEP_SZ)
    ) pixel_generator_inst (
        .out_stream_aclk(out_stream_aclk), .axi_resetn(axi_resetn),
        .out_stream_tdata_o(tdata), .out_stream_tkeep_o(tkeep), .out_stream_tlast_o(tlast),
        .out_stream_tready_i(tready), .out_stream_tvalid_o(tvalid), .out_stream_tuser_o(tuser),
        .s_axi_lite_araddr_i(araddr), .s_axi_lite_arvalid_i(arvalid),
        .s_axi_lite_arready_o(arready),
        .s_axi_lite_awaddr_i(awaddr), .s_axi_lite_awvalid_i(awvalid),
        .s_axi_lite_awready_o(awready),
        .s_axi_lite_wdata_i(wdata), .s_axi_lite_wvalid_i(wvalid), .s_axi_lite_wready_o(wready),
        .s_axi_lite_bready_i(bready), .s_axi_lite_bresp_o(bresp), .s_axi_lite_bvalid_o(bvalid),
        .s_axi_lite_rdata_o(rdata), .s_axi_lite_rready_i(rready), .s_axi_lite_rresp_o(rresp),
        .s_axi_lite_rvalid_o(rvalid)
    );

    initial begin
        out_stream_aclk = 1'b0;
        forever #50 out_stream_aclk = ~out_stream_aclk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "wait loop expired");
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] order, output logic [1:0] resp);
        bit aw_pend, w_pend;
        int n;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        n       = 0;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= (order != 2'd2);
        wvalid  <= (order != 2'd1);
        while (aw_pend || w_pend) begin
            @(posedge out_stream_aclk);
            if (awvalid && awready) begin
                aw_pend = 1'b0;
                awvalid <= 1'b0;
                if (w_pend) wvalid <= 1'b1;    // data follows address
            end
            if (wvalid && wready) begin
                w_pend = 1'b0;
                wvalid <= 1'b0;
                if (aw_pend) awvalid <= 1'b1;
            end
            n++;
            if (n > TIMEOUT) timeout_abort("write address and data acceptance");
        end
        n = 0;
        do begin
            @(posedge out_stream_aclk);
            n++;
            if (n > TIMEOUT) timeout_abort("bvalid");
        end while (!bvalid);
        check_value("bvalid latency", n, 2);
        resp = bresp;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        n = 0;
        araddr  <= addr;
        arvalid <= 1'b1;
        do begin
            @(posedge out_stream_aclk);
            n++;
            if (n > TIMEOUT) timeout_abort("arready");
        end while (!arready);
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge out_stream_aclk);
            n++;
            if (n > TIMEOUT) timeout_abort("rvalid");
        end while (!rvalid);
        check_value("rvalid latency", n, 2);
        data = rdata;
        resp = rresp;
    endtask

    // escape-time rule in 8.24, products scaled back by the fraction width
    function automatic logic [31:0] model_pixel(input int px, input int py);
        longint cx, cy, zx, zy, zx2, zy2, zxy;
        int n;
        logic [15:0] it;
        cx = longint'(X_ORG) + longint'(px) * longint'(STEP_SZ);
        cy = longint'(Y_ORG) + longint'(py) * longint'(STEP_SZ);
        zx = 0;
        zy = 0;
        for (n = 0; n < MAX_ITER; n++) begin
            zx2 = (zx * zx) >>> `FRAC_BITS;
            zy2 = (zy * zy) >>> `FRAC_BITS;
            zxy = (zx * zy) >>> `FRAC_BITS;
            if (zx2 + zy2 > longint'(`ESCAPE_LIMIT)) break;
            zx = longint'(int'(zx2 - zy2 + cx));
            zy = longint'(int'(2 * zxy + cy));
        end
        it = 16'(n);
        return {8'h00, it[7:0], it[7:0], it[15:8]};
    endfunction

    task automatic take_beats(input int count, input bit random_ready);
        int got, idle;
        bit stalled;
        logic [31:0] held_data;
        logic held_user, held_last;
        got     = 0;
        idle    = 0;
        stalled = 1'b0;
        while (got < count) begin
            @(posedge out_stream_aclk);
            if (stalled) begin    // beat must hold under back-pressure
                check_value("out_stream_tvalid", tvalid, 1);
                check_value("out_stream_tdata", tdata, held_data);
                check_value("out_stream_tuser", tuser, held_user);
                check_value("out_stream_tlast", tlast, held_last);
            end
            stalled   = tvalid && !tready;
            held_data = tdata;
            held_user = tuser;
            held_last = tlast;
            if (tvalid && tready) begin
                check_value("out_stream_tdata",
                            tdata, model_pixel(beat_idx % X_SZ, (beat_idx / X_SZ) % Y_SZ));
                check_value("out_stream_tkeep", tkeep, 4'hF);
                check_value("out_stream_tuser", tuser, (beat_idx % (X_SZ * Y_SZ)) == 0);
                check_value("out_stream_tlast", tlast, (beat_idx % X_SZ) == X_SZ - 1);
                beat_idx++;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) timeout_abort("a stream beat");
            end
            tready <= random_ready ? 1'($urandom % 2) : 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        logic [1:0]  rs;
        void'($urandom(99));
        axi_resetn = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        rready     = 1'b1;
        tready     = 1'b0;
        beat_idx   = 0;
        repeat (3) @(posedge out_stream_aclk);
        axi_resetn <= 1'b1;
        @(posedge out_stream_aclk);

        for (int i = 0; i < 22; i++) begin
            if (reg_ops[i].wr) begin
                write_reg(reg_ops[i].addr, reg_ops[i].data, reg_ops[i].order, rs);
                check_value("s_axi_lite_bresp", rs, reg_ops[i].exp_resp);
            end else begin
                read_reg(reg_ops[i].addr, rd, rs);
                check_value("s_axi_lite_rdata", rd, reg_ops[i].exp_data);
                check_value("s_axi_lite_rresp", rs, reg_ops[i].exp_resp);
            end
        end

        repeat (200) begin    // no output before run
            @(posedge out_stream_aclk);
            check_value("out_stream_tvalid", tvalid, 0);
        end

        write_reg(8'h04, 32'h1, 2'd0, rs);
        check_value("s_axi_lite_bresp", rs, RSP_OK);
        tready <= 1'b1;
        take_beats(2 * X_SZ * Y_SZ, 1'b0);
        take_beats(2 * X_SZ * Y_SZ, 1'b1);   // random back-pressure

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/fractal_pkg.sv
design/axi_lite_regs.sv
fractal/pixel_coord_gen.sv
fractal/escape_core.sv
fractal/core_scheduler.sv
design/pixel_generator.sv
sim/tb_pixel_generator.sv
